// File: design/mmu_params.svh
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

/////////////////////////////
// Sv39 address geometry
/////////////////////////////

`define VIRT_ADDR_LEN   39
`define PHYS_ADDR_LEN   56
`define PAGE_OFFSET_LEN 12

// Page numbers with the page offset stripped
`define VPN_LEN         27
`define PPN_LEN         44

/////////////////////////////
// Translation unit sizing
/////////////////////////////

`define ASID_LEN        16
`define TLB_ENTRIES     8
`define PT_LEVELS       3

`endif

// File: design/sv39_pkg.sv
`include "mmu_params.svh"

package sv39_pkg;

  ///////////////////////////////
  // Page permissions
  ///////////////////////////////

  // Same bit order as the low byte of a PTE, valid in bit 0
  typedef struct packed {
    logic dirty;
    logic accessed;
    logic is_global;
    logic user;
    logic execute;
    logic write;
    logic read;
    logic valid;
  } page_prot_t;

  ///////////////////////////////
  // Page table entry
  ///////////////////////////////

  // Leaf and pointer share this layout
  typedef struct packed {
    logic [63-`PPN_LEN-10:0] reserved;
    logic [`PPN_LEN-1:0]     ppn;
    logic [1:0]              rsw;
    page_prot_t              perm;
  } sv39_pte_t;

  ///////////////////////////////
  // satp CSR
  ///////////////////////////////

  // Only Sv39 is handled, mode is carried but not decoded
  typedef struct packed {
    logic [3:0]           mode;
    logic [`ASID_LEN-1:0] asid;
    logic [`PPN_LEN-1:0]  ppn;
  } satp_t;

endpackage

// File: design/walk_pkg.sv
package walk_pkg;

  ///////////////////////////////
  // Walker FSM
  ///////////////////////////////

  typedef enum logic [1:0] {
    PTW_IDLE      = 2'd0,
    PTW_READ_REQ  = 2'd1,
    PTW_READ_WAIT = 2'd2,
    PTW_RESPOND   = 2'd3
  } ptw_state_e;

  // Why a walk ended without a usable leaf
  typedef enum logic [1:0] {
    FAULT_NONE       = 2'd0,
    FAULT_INVALID    = 2'd1,
    FAULT_MISALIGNED = 2'd2,
    FAULT_LEVEL      = 2'd3
  } walk_fault_e;

endpackage

// File: design/mmu_tlb.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_tlb import sv39_pkg::*; #(
  parameter int unsigned NumEntry = `TLB_ENTRIES,
  parameter int unsigned AsidLen  = `ASID_LEN
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic [63:0]         satp_i,

  // Lookup from the requester
  input  logic                req_valid_i,
  input  logic [`VPN_LEN-1:0] req_vpn_i,
  output logic                resp_valid_o,
  output logic [`PPN_LEN-1:0] resp_ppn_o,
  output page_prot_t          resp_perm_o,

  input  logic                flush_req_i,
  output logic                flush_resp_o,

  // Walk request toward the PTW
  input  logic                ptw_req_ready_i,
  output logic                ptw_req_valid_o,
  output logic [`VPN_LEN-1:0] ptw_req_vpn_o,

  // Walk result, single cycle pulse
  input  logic                ptw_resp_valid_i,
  input  logic [`PPN_LEN-1:0] ptw_resp_ppn_i,
  input  page_prot_t          ptw_resp_perm_i
);

  localparam int unsigned IdxLen = (NumEntry > 1) ? $clog2(NumEntry) : 1;

  satp_t              satp;
  logic [AsidLen-1:0] cur_asid;

  assign satp     = satp_t'(satp_i);
  assign cur_asid = satp.asid[AsidLen-1:0];

  // Entry storage, only the valid flags are reset
  logic [NumEntry-1:0] valid_q;
  logic [`VPN_LEN-1:0] tag_vpn_q   [NumEntry];
  logic [AsidLen-1:0]  tag_asid_q  [NumEntry];
  logic [`PPN_LEN-1:0] data_ppn_q  [NumEntry];
  page_prot_t          data_perm_q [NumEntry];

  //////////////////////////////
  // Lookup
  //////////////////////////////

  logic [NumEntry-1:0] hit_vec;
  logic                hit;
  logic [`PPN_LEN-1:0] hit_ppn;
  page_prot_t          hit_perm;

  // Faulted entries keep perm.valid low and never match
  always_comb begin
    for (int i = 0; i < NumEntry; i++) begin
      hit_vec[i] = valid_q[i] && data_perm_q[i].valid &&
                   (tag_vpn_q[i] == req_vpn_i) &&
                   (data_perm_q[i].is_global || (tag_asid_q[i] == cur_asid));
    end
  end

  assign hit = |hit_vec;

  always_comb begin
    hit_ppn  = '0;
    hit_perm = '0;
    for (int i = 0; i < NumEntry; i++) begin
      if (hit_vec[i]) begin
        hit_ppn  = data_ppn_q[i];
        hit_perm = data_perm_q[i];
      end
    end
  end

  //////////////////////////////
  // Miss handling
  //////////////////////////////

  logic miss;
  logic ptw_fire;

  assign miss     = req_valid_i && !hit;
  assign ptw_fire = ptw_req_valid_o && ptw_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptw_req_valid_o <= 1'b0;
    end else if (miss) begin
      ptw_req_valid_o <= 1'b1;
    end else if (ptw_fire) begin
      ptw_req_valid_o <= 1'b0;
    end
  end

  // Also serves as the refill tag once the walk returns
  always_ff @(posedge clk_i) begin
    if (miss) begin
      ptw_req_vpn_o <= req_vpn_i;
    end
  end

  //////////////////////////////
  // Refill and flush
  //////////////////////////////

  logic [IdxLen-1:0] repl_idx_q;

  // Flush wins over a refill in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      repl_idx_q <= '0;
    end else begin
      if (ptw_resp_valid_i) begin
        valid_q[repl_idx_q] <= 1'b1;
        repl_idx_q <= (repl_idx_q == IdxLen'(NumEntry - 1)) ? '0 : repl_idx_q + 1'b1;
      end
      if (flush_req_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ptw_resp_valid_i) begin
      tag_vpn_q[repl_idx_q]   <= ptw_req_vpn_o;
      tag_asid_q[repl_idx_q]  <= cur_asid;
      data_ppn_q[repl_idx_q]  <= ptw_resp_ppn_i;
      data_perm_q[repl_idx_q] <= ptw_resp_perm_i;
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  logic                hit_q;
  logic [`PPN_LEN-1:0] hit_ppn_q;
  page_prot_t          hit_perm_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_q        <= 1'b0;
      flush_resp_o <= 1'b0;
    end else begin
      hit_q        <= req_valid_i && hit;
      flush_resp_o <= flush_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && hit) begin
      hit_ppn_q  <= hit_ppn;
      hit_perm_q <= hit_perm;
    end
  end

  // Walk result goes straight through while it is being stored
  assign resp_valid_o = hit_q || ptw_resp_valid_i;
  assign resp_ppn_o   = hit_q ? hit_ppn_q : ptw_resp_ppn_i;
  assign resp_perm_o  = hit_q ? hit_perm_q : ptw_resp_perm_i;

endmodule

// File: design/mmu_ptw.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_ptw import sv39_pkg::*, walk_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  logic [63:0]              satp_i,

  // Walk request from the TLB
  input  logic                     ptw_req_valid_i,
  input  logic [`VPN_LEN-1:0]      ptw_req_vpn_i,
  output logic                     ptw_req_ready_o,

  // Walk result
  output logic                     ptw_resp_valid_o,
  output logic [`PPN_LEN-1:0]      ptw_resp_ppn_o,
  output page_prot_t               ptw_resp_perm_o,

  // Page table memory port
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  output logic [`PHYS_ADDR_LEN-1:0] mem_req_addr_o,
  input  logic                     mem_resp_valid_i,
  input  logic [63:0]              mem_resp_data_i,

  output walk_fault_e              fault_o
);

  localparam int unsigned SliceLen = (`VIRT_ADDR_LEN - `PAGE_OFFSET_LEN) / `PT_LEVELS;
  localparam int unsigned LevelLen = $clog2(`PT_LEVELS);
  // 8 bytes per PTE
  localparam int unsigned PteOffLen = `PAGE_OFFSET_LEN - SliceLen;

  ptw_state_e          state_q;
  ptw_state_e          state_d;
  logic [LevelLen-1:0] level_q;
  logic [`VPN_LEN-1:0] vpn_q;
  logic [`PPN_LEN-1:0] table_ppn_q;

  satp_t     satp;
  sv39_pte_t pte;

  assign satp = satp_t'(satp_i);
  assign pte  = sv39_pte_t'(mem_resp_data_i);

  //////////////////////////////
  // Memory request
  //////////////////////////////

  logic [SliceLen-1:0] vpn_slice;

  // Table base plus VPN slice of the current level
  assign vpn_slice       = vpn_q[level_q * SliceLen +: SliceLen];
  assign mem_req_valid_o = (state_q == PTW_READ_REQ);
  assign mem_req_addr_o  = {table_ppn_q, vpn_slice, {PteOffLen{1'b0}}};

  //////////////////////////////
  // PTE decode
  //////////////////////////////

  logic                is_leaf;
  logic                is_pointer;
  logic [`PPN_LEN-1:0] super_mask;
  logic [`PPN_LEN-1:0] vpn_ext;
  logic [`PPN_LEN-1:0] leaf_ppn;
  logic                super_misaligned;
  walk_fault_e         pte_fault;

  assign is_leaf    = pte.perm.read || pte.perm.execute;
  assign is_pointer = pte.perm.valid && !is_leaf;

  // PPN slices below the current level, empty at level 0
  assign super_mask       = ~({`PPN_LEN{1'b1}} << (level_q * SliceLen));
  assign vpn_ext          = {{(`PPN_LEN - `VPN_LEN){1'b0}}, vpn_q};
  assign super_misaligned = |(pte.ppn & super_mask);

  // Superpages become a 4 KiB translation
  assign leaf_ppn = (pte.ppn & ~super_mask) | (vpn_ext & super_mask);

  always_comb begin
    if (!pte.perm.valid) begin
      pte_fault = FAULT_INVALID;
    end else if (is_pointer && (level_q == '0)) begin
      pte_fault = FAULT_LEVEL;
    end else if (is_leaf && super_misaligned) begin
      pte_fault = FAULT_MISALIGNED;
    end else begin
      pte_fault = FAULT_NONE;
    end
  end

  //////////////////////////////
  // Walk FSM
  //////////////////////////////

  logic req_fire;
  logic pte_rcvd;
  logic walk_step;
  logic walk_done;

  assign req_fire  = ptw_req_valid_i && ptw_req_ready_o;
  assign pte_rcvd  = (state_q == PTW_READ_WAIT) && mem_resp_valid_i;
  assign walk_step = pte_rcvd && is_pointer && (pte_fault == FAULT_NONE);
  assign walk_done = pte_rcvd && !walk_step;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      PTW_IDLE:      if (ptw_req_valid_i) state_d = PTW_READ_REQ;
      PTW_READ_REQ:  if (mem_req_ready_i) state_d = PTW_READ_WAIT;
      PTW_READ_WAIT: begin
        if (walk_step) begin
          state_d = PTW_READ_REQ;
        end else if (walk_done) begin
          state_d = PTW_RESPOND;
        end
      end
      PTW_RESPOND:   state_d = PTW_IDLE;
      default:       state_d = PTW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PTW_IDLE;
      level_q <= '0;
      fault_o <= FAULT_NONE;
    end else begin
      state_q <= state_d;
      if (req_fire) begin
        level_q <= LevelLen'(`PT_LEVELS - 1);
      end else if (walk_step) begin
        level_q <= level_q - 1'b1;
      end
      if (walk_done) begin
        fault_o <= pte_fault;
      end
    end
  end

  //////////////////////////////
  // Walk payload and result
  //////////////////////////////

  page_prot_t resp_perm_d;

  // Faults hand back the PTE flags with valid forced low
  always_comb begin
    resp_perm_d       = pte.perm;
    resp_perm_d.valid = (pte_fault == FAULT_NONE);
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      vpn_q       <= ptw_req_vpn_i;
      table_ppn_q <= satp.ppn;
    end else if (walk_step) begin
      table_ppn_q <= pte.ppn;
    end
    if (walk_done) begin
      ptw_resp_ppn_o  <= (pte_fault == FAULT_NONE) ? leaf_ppn : '0;
      ptw_resp_perm_o <= resp_perm_d;
    end
  end

  assign ptw_req_ready_o  = (state_q == PTW_IDLE);
  assign ptw_resp_valid_o = (state_q == PTW_RESPOND);

endmodule

// File: design/mmu_top.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_top import sv39_pkg::*, walk_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic [63:0]               satp_i,

  // Lookup port
  input  logic                      req_valid_i,
  input  logic [`VPN_LEN-1:0]       req_vpn_i,
  output logic                      resp_valid_o,
  output logic [`PPN_LEN-1:0]       resp_ppn_o,
  output page_prot_t                resp_perm_o,

  input  logic                      flush_req_i,
  output logic                      flush_resp_o,

  // Page table memory port
  output logic                      mem_req_valid_o,
  input  logic                      mem_req_ready_i,
  output logic [`PHYS_ADDR_LEN-1:0] mem_req_addr_o,
  input  logic                      mem_resp_valid_i,
  input  logic [63:0]               mem_resp_data_i,

  // Cause of the most recent walk end, for debug
  output walk_fault_e               walk_fault_o
);

  // TLB to walker
  logic                ptw_req_valid;
  logic                ptw_req_ready;
  logic [`VPN_LEN-1:0] ptw_req_vpn;
  logic                ptw_resp_valid;
  logic [`PPN_LEN-1:0] ptw_resp_ppn;
  page_prot_t          ptw_resp_perm;

  mmu_tlb #(
    .NumEntry (`TLB_ENTRIES),
    .AsidLen  (`ASID_LEN)
  ) i_tlb (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .satp_i           (satp_i),
    .req_valid_i      (req_valid_i),
    .req_vpn_i        (req_vpn_i),
    .resp_valid_o     (resp_valid_o),
    .resp_ppn_o       (resp_ppn_o),
    .resp_perm_o      (resp_perm_o),
    .flush_req_i      (flush_req_i),
    .flush_resp_o     (flush_resp_o),
    .ptw_req_ready_i  (ptw_req_ready),
    .ptw_req_valid_o  (ptw_req_valid),
    .ptw_req_vpn_o    (ptw_req_vpn),
    .ptw_resp_valid_i (ptw_resp_valid),
    .ptw_resp_ppn_i   (ptw_resp_ppn),
    .ptw_resp_perm_i  (ptw_resp_perm)
  );

  mmu_ptw i_ptw (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .satp_i           (satp_i),
    .ptw_req_valid_i  (ptw_req_valid),
    .ptw_req_vpn_i    (ptw_req_vpn),
    .ptw_req_ready_o  (ptw_req_ready),
    .ptw_resp_valid_o (ptw_resp_valid),
    .ptw_resp_ppn_o   (ptw_resp_ppn),
    .ptw_resp_perm_o  (ptw_resp_perm),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .fault_o          (walk_fault_o)
  );

endmodule

// File: testbench/tb_mmu.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module tb_mmu import sv39_pkg::*, walk_pkg::*;;

  logic                      clk_i;
  logic                      rst_ni;
  logic [63:0]               satp_i;
  logic                      req_valid_i;
  logic [`VPN_LEN-1:0]       req_vpn_i;
  logic                      resp_valid_o;
  logic [`PPN_LEN-1:0]       resp_ppn_o;
  page_prot_t                resp_perm_o;
  logic                      flush_req_i;
  logic                      flush_resp_o;
  logic                      mem_req_valid_o;
  logic                      mem_req_ready_i;
  logic [`PHYS_ADDR_LEN-1:0] mem_req_addr_o;
  logic                      mem_resp_valid_i;
  logic [63:0]               mem_resp_data_i;
  walk_fault_e               walk_fault_o;

  mmu_top i_dut (.*);

  // Sparse page table memory
  logic [63:0] pt_mem [logic [`PHYS_ADDR_LEN-1:0]];
  logic [`PPN_LEN-1:0] root_ppn   = 44'h100;
  logic [`PPN_LEN-1:0] next_table = 44'h200;

  // Expected response of the lookup in flight
  string               test_name = "reset";
  logic                exp_hit;
  logic [`PPN_LEN-1:0] exp_ppn;
  page_prot_t          exp_perm;
  walk_fault_e         exp_fault;
  int                  mem_reads;
  int                  reads_at_req;
  int                  errors;
  int                  cycle;
  logic [31:0]         lfsr_q = 32'd83;

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic lfsr_step();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) lfsr_q = lfsr_q ^ 32'hA3000000;
    return out;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  function automatic logic [`PHYS_ADDR_LEN-1:0] pte_addr(input logic [`PPN_LEN-1:0] tbl,
                                                        input logic [`VPN_LEN-1:0] vpn,
                                                        input int lvl);
    return {tbl, 12'h000} + (56'((vpn >> (9 * lvl)) & 27'h1ff) << 3);
  endfunction

  function automatic sv39_pte_t read_pte(input logic [`PHYS_ADDR_LEN-1:0] addr);
    return sv39_pte_t'(pt_mem.exists(addr) ? pt_mem[addr] : 64'h0);
  endfunction

  function automatic page_prot_t leaf_perm(input logic glob);
    page_prot_t p;
    p           = '0;
    p.valid     = 1'b1;
    p.read      = 1'b1;
    p.write     = 1'b1;
    p.is_global = glob;
    p.accessed  = 1'b1;
    p.dirty     = 1'b1;
    return p;
  endfunction

  // Builds pointer tables down to leaf_level, then writes the leaf
  task automatic map_leaf(input logic [`VPN_LEN-1:0] vpn, input int leaf_level,
                          input logic [`PPN_LEN-1:0] ppn, input page_prot_t perm);
    logic [`PPN_LEN-1:0] tbl;
    sv39_pte_t           pte;
    tbl = root_ppn;
    for (int lvl = 2; lvl > leaf_level; lvl--) begin
      pte = read_pte(pte_addr(tbl, vpn, lvl));
      if (!pte.perm.valid) begin
        pte            = '0;
        pte.ppn        = next_table;
        pte.perm.valid = 1'b1;
        next_table     = next_table + 44'd1;
        pt_mem[pte_addr(tbl, vpn, lvl)] = pte;
      end
      tbl = pte.ppn;
    end
    pte      = '0;
    pte.ppn  = ppn;
    pte.perm = perm;
    pt_mem[pte_addr(tbl, vpn, leaf_level)] = pte;
  endtask

  // Reference Sv39 walk over the same memory
  function automatic void model_walk(input logic [`VPN_LEN-1:0] vpn,
                                     output logic [`PPN_LEN-1:0] ppn,
                                     output page_prot_t perm, output walk_fault_e fault);
    logic [`PPN_LEN-1:0] tbl;
    logic [`PPN_LEN-1:0] mask;
    sv39_pte_t           pte;
    tbl   = root_ppn;
    ppn   = '0;
    perm  = '0;
    fault = FAULT_INVALID;
    for (int lvl = 2; lvl >= 0; lvl--) begin
      pte  = read_pte(pte_addr(tbl, vpn, lvl));
      mask = (44'd1 << (9 * lvl)) - 44'd1;
      perm = pte.perm;
      if (!pte.perm.valid) begin
        fault = FAULT_INVALID;
        break;
      end
      if (pte.perm.read || pte.perm.execute) begin
        if ((pte.ppn & mask) != '0) begin
          fault = FAULT_MISALIGNED;
        end else begin
          fault = FAULT_NONE;
          ppn   = (pte.ppn & ~mask) | ({17'h0, vpn} & mask);
        end
        break;
      end
      if (lvl == 0) begin
        fault = FAULT_LEVEL;
        break;
      end
      tbl = pte.ppn;
    end
    perm.valid = (fault == FAULT_NONE);
  endfunction

  //////////////////////////////
  // Memory model
  //////////////////////////////

  logic                      mem_pending;
  int                        mem_delay;
  logic [`PHYS_ADDR_LEN-1:0] mem_addr_q;

  always @(posedge clk_i) begin
    mem_resp_valid_i <= 1'b0;
    if (!rst_ni) begin
      mem_pending = 1'b0;
      mem_reads   <= 0;
    end else begin
      if (mem_pending) begin
        if (mem_delay == 0) begin
          mem_resp_valid_i <= 1'b1;
          mem_resp_data_i  <= read_pte(mem_addr_q);
          mem_pending = 1'b0;
        end else begin
          mem_delay = mem_delay - 1;
        end
      end else if (mem_req_valid_o && mem_req_ready_i) begin
        mem_pending = 1'b1;
        mem_addr_q  = mem_req_addr_o;
        mem_delay   = int'(lfsr_bits(2));
        mem_reads   <= mem_reads + 1;
      end
      // Ready about three cycles in four
      mem_req_ready_i <= (lfsr_bits(2) != 32'd0);
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_resp_ppn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> resp_ppn_o == exp_ppn)
    else begin
      errors++;
      $display("Error %s: ppn expected %h, actual %h", test_name,
               $sampled(exp_ppn), $sampled(resp_ppn_o));
    end

  a_resp_perm: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> resp_perm_o == exp_perm)
    else begin
      errors++;
      $display("Error %s: perm expected %h, actual %h", test_name,
               $sampled(exp_perm), $sampled(resp_perm_o));
    end

  a_fault: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_valid_o && !exp_hit) |-> walk_fault_o == exp_fault)
    else begin
      errors++;
      $display("Error %s: fault expected %0d, actual %0d", test_name,
               $sampled(exp_fault), $sampled(walk_fault_o));
    end

  a_hit_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && exp_hit) |=> resp_valid_o)
    else begin
      errors++;
      $display("%s: expected a hit response one cycle after the request", test_name);
    end

  // A walk started by the hit would show its memory request by now
  a_hit_no_mem: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(req_valid_i && exp_hit, 2) |-> !mem_req_valid_o)
    else begin
      errors++;
      $display("%s: a hit issued a memory request", test_name);
    end

  a_miss_walk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && !exp_hit) |=> (i_dut.ptw_req_valid && !resp_valid_o))
    else begin
      errors++;
      $display("%s: a miss did not raise the walk request one cycle later", test_name);
    end

  a_walk_reads: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_valid_o && !exp_hit) |-> mem_reads > reads_at_req)
    else begin
      errors++;
      $display("%s: a walk finished without any memory read", test_name);
    end

  a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_valid_o && !mem_req_ready_i) |=> (mem_req_valid_o && $stable(mem_req_addr_o)))
    else begin
      errors++;
      $display("Memory request dropped or changed its address while stalled");
    end

  a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_req_i |=> (flush_resp_o && i_dut.i_tlb.valid_q == '0))
    else begin
      errors++;
      $display("Flush was not answered one cycle later with all entries cleared");
    end

  a_reset_quiet: assert property (@(posedge clk_i) (!rst_ni && cycle > 1) |->
    (!resp_valid_o && !flush_resp_o && !mem_req_valid_o && !i_dut.ptw_req_valid &&
     i_dut.i_tlb.valid_q == '0))
    else begin
      errors++;
      $display("Outputs or entry valid flags not low during reset");
    end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic lookup(input string name, input logic [`VPN_LEN-1:0] vpn, input logic hit);
    logic [`PPN_LEN-1:0] ppn;
    page_prot_t          perm;
    walk_fault_e         fault;
    int                  waited;
    model_walk(vpn, ppn, perm, fault);
    @(posedge clk_i);
    req_valid_i  <= 1'b1;
    req_vpn_i    <= vpn;
    test_name    <= name;
    exp_hit      <= hit;
    exp_ppn      <= ppn;
    exp_perm     <= perm;
    exp_fault    <= fault;
    reads_at_req <= mem_reads;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!resp_valid_o && waited < 500) begin
      @(negedge clk_i);
      waited++;
    end
    if (!resp_valid_o) begin
      errors++;
      $display("Timeout: no response to the lookup in %s", name);
    end
    @(posedge clk_i);
  endtask

  task automatic flush_tlb();
    int waited;
    @(posedge clk_i);
    flush_req_i <= 1'b1;
    @(posedge clk_i);
    flush_req_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!flush_resp_o && waited < 50) begin
      @(negedge clk_i);
      waited++;
    end
    if (!flush_resp_o) begin
      errors++;
      $display("Timeout: flush was never answered");
    end
  endtask

  task automatic set_asid(input logic [15:0] asid);
    @(posedge clk_i);
    satp_i <= {4'h8, asid, root_ppn};
  endtask

  logic [`VPN_LEN-1:0] rnd_vpn [9];
  logic [`VPN_LEN-1:0] vpn_2m   = {9'h101, 9'h005, 9'h033};
  logic [`VPN_LEN-1:0] vpn_1g   = {9'h102, 9'h007, 9'h044};
  logic [`VPN_LEN-1:0] vpn_inv  = {9'h103, 9'h001, 9'h002};
  logic [`VPN_LEN-1:0] vpn_mis  = {9'h104, 9'h011, 9'h022};
  logic [`VPN_LEN-1:0] vpn_lvl  = {9'h106, 9'h003, 9'h004};
  logic [`VPN_LEN-1:0] vpn_glob = {9'h105, 9'h00a, 9'h0b0};

  initial begin
    page_prot_t ptr_perm;
    rst_ni           = 1'b0;
    satp_i           = {4'h8, 16'h0001, root_ppn};
    req_valid_i      = 1'b0;
    req_vpn_i        = '0;
    flush_req_i      = 1'b0;
    mem_req_ready_i  = 1'b0;
    mem_resp_valid_i = 1'b0;
    mem_resp_data_i  = '0;
    exp_hit          = 1'b0;
    exp_ppn          = '0;
    exp_perm         = '0;
    exp_fault        = FAULT_NONE;
    errors           = 0;
    cycle            = 0;
    reads_at_req     = 0;

    // Random 4 KiB pages stay in the lower half of the top slice
    for (int i = 0; i < 9; i++) begin
      rnd_vpn[i] = {1'b0, 26'(lfsr_bits(26))};
      map_leaf(rnd_vpn[i], 0, {24'h0, 20'(lfsr_bits(20))}, leaf_perm(1'b0));
    end
    map_leaf(vpn_2m, 1, 44'h0000_0abc_e00, leaf_perm(1'b0));
    map_leaf(vpn_1g, 2, 44'h0000_0480_000, leaf_perm(1'b0));
    map_leaf(vpn_mis, 1, 44'h0000_0123_405, leaf_perm(1'b0));
    map_leaf(vpn_glob, 0, 44'h0000_0077_123, leaf_perm(1'b1));
    ptr_perm       = '0;
    ptr_perm.valid = 1'b1;
    map_leaf(vpn_lvl, 0, 44'h0000_0000_999, ptr_perm);

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < 6; i++) lookup("miss_4k", rnd_vpn[i], 1'b0);
    for (int i = 0; i < 6; i++) lookup("hit_4k", rnd_vpn[i], 1'b1);

    // ASID switch, the global page survives it
    lookup("global_fill", vpn_glob, 1'b0);
    set_asid(16'h0002);
    lookup("asid_miss", rnd_vpn[5], 1'b0);
    lookup("global_hit", vpn_glob, 1'b1);

    lookup("super_2m", vpn_2m, 1'b0);
    lookup("super_1g", vpn_1g, 1'b0);
    lookup("fault_invalid", vpn_inv, 1'b0);
    lookup("fault_misaligned", vpn_mis, 1'b0);
    lookup("fault_level", vpn_lvl, 1'b0);
    lookup("super_2m_hit", vpn_2m, 1'b1);
    lookup("fault_repeat", vpn_inv, 1'b0);

    flush_tlb();
    lookup("flush_miss", vpn_2m, 1'b0);

    // Nine refills into eight slots
    flush_tlb();
    for (int i = 0; i < 9; i++) lookup("fill", rnd_vpn[i], 1'b0);
    lookup("evict_hit", rnd_vpn[8], 1'b1);
    lookup("evict_miss", rnd_vpn[0], 1'b0);

    repeat (4) @(posedge clk_i);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+design
design/sv39_pkg.sv
design/walk_pkg.sv
design/mmu_tlb.sv
design/mmu_ptw.sv
design/mmu_top.sv
testbench/tb_mmu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mmu
FILELIST  ?= build.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the run prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
